/* hw/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Core size
`define CPU_NUM_REGS 8
`define CPU_IM_WORDS 64

// Host command bytes
`define CMD_LOAD 8'h4C
`define CMD_RUN  8'h52
`define CMD_STEP 8'h53

// PC word plus eight register words
`define REPORT_BYTES 36

`endif

/* hw/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [7:0]  im_addr_t;
    typedef logic [3:0]  opcode_t;

    // Instruction word layout
    //   [31:28] opcode, [27:25] rd, [24:22] rs, [21:19] rt, [15:0] signed imm
    // Unlisted opcodes behave as NOP; r0 reads zero and ignores writes
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_ADDI = 4'd1;
    localparam opcode_t OP_ADD  = 4'd2;
    localparam opcode_t OP_SUB  = 4'd3;
    localparam opcode_t OP_AND  = 4'd4;
    localparam opcode_t OP_OR   = 4'd5;
    localparam opcode_t OP_HALT = 4'd15;

    // Debug FSM, one-hot
    typedef enum logic [7:0] {
        IDLE        = 8'b0000_0001,
        LOAD_COUNT  = 8'b0000_0010,
        LOAD_BYTES  = 8'b0000_0100,
        RUN         = 8'b0000_1000,
        STEP        = 8'b0001_0000,
        REPORT_SEND = 8'b0010_0000,
        REPORT_WAIT = 8'b0100_0000,
        ERROR_FLUSH = 8'b1000_0000
    } du_state_t;

endpackage

/* hw/data_path.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module data_path (
    input  logic                             i_clock,
    input  logic                             i_rst,
    input  logic                             i_enable,
    input  logic                             i_clear,
    input  cpu_pkg::word_t                   i_instr,
    input  logic [3:0]                       i_report_sel,
    output logic [$clog2(`CPU_IM_WORDS)-1:0] o_pc,
    output logic                             o_hlt,
    output cpu_pkg::word_t                   o_report_word
);

    logic [$clog2(`CPU_IM_WORDS)-1:0] pc;
    logic                             halted;

    cpu_pkg::word_t regs [`CPU_NUM_REGS];

    cpu_pkg::opcode_t  opcode;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::word_t    imm_ext;
    cpu_pkg::word_t    rs_val;
    cpu_pkg::word_t    rt_val;
    cpu_pkg::word_t    alu_res;
    logic              alu_op;
    logic              is_halt;
    logic              exec;
    logic              wr_en;

    // Field decode
    assign opcode  = i_instr[31:28];
    assign rd      = i_instr[27:25];
    assign rs      = i_instr[24:22];
    assign rt      = i_instr[21:19];
    assign imm_ext = {{16{i_instr[15]}}, i_instr[15:0]};

    // r0 is never written, so it stays zero
    assign rs_val = regs[rs];
    assign rt_val = regs[rt];

    always_comb begin
        alu_res = '0;
        alu_op  = 1'b0;
        case (opcode)
            cpu_pkg::OP_ADDI: begin
                alu_res = rs_val + imm_ext;
                alu_op  = 1'b1;
            end
            cpu_pkg::OP_ADD: begin
                alu_res = rs_val + rt_val;
                alu_op  = 1'b1;
            end
            cpu_pkg::OP_SUB: begin
                alu_res = rs_val - rt_val;
                alu_op  = 1'b1;
            end
            cpu_pkg::OP_AND: begin
                alu_res = rs_val & rt_val;
                alu_op  = 1'b1;
            end
            cpu_pkg::OP_OR: begin
                alu_res = rs_val | rt_val;
                alu_op  = 1'b1;
            end
            default: begin
                alu_res = '0;
                alu_op  = 1'b0;
            end
        endcase
    end

    assign is_halt = (opcode == cpu_pkg::OP_HALT);
    assign exec    = i_enable && !halted;
    assign wr_en   = exec && alu_op && (rd != '0);

    always_ff @(posedge i_clock) begin
        if (i_rst || i_clear) begin
            pc     <= '0;
            halted <= 1'b0;
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (exec) begin
            // PC holds on HALT
            if (is_halt) begin
                halted <= 1'b1;
            end else begin
                pc <= pc + 1'b1;
            end
            if (wr_en) begin
                regs[rd] <= alu_res;
            end
        end
    end

    // Report port, 0 is PC and 1..8 are r0..r7
    always_comb begin
        if (i_report_sel == 4'd0) begin
            o_report_word = cpu_pkg::word_t'(pc);
        end else if (i_report_sel <= 4'(`CPU_NUM_REGS)) begin
            o_report_word = regs[3'(i_report_sel - 4'd1)];
        end else begin
            o_report_word = '0;
        end
    end

    assign o_pc  = pc;
    assign o_hlt = halted;

endmodule

/* hw/debug_unit.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module debug_unit (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_rx_done,
    input  cpu_pkg::byte_t     i_rx_data,
    input  logic               i_tx_done,
    input  logic               i_hlt,
    input  cpu_pkg::word_t     i_report_word,
    output logic               o_im_write,
    output cpu_pkg::im_addr_t  o_im_addr,
    output cpu_pkg::byte_t     o_im_data,
    output logic               o_cpu_enable,
    output logic               o_core_clear,
    output logic [3:0]         o_report_sel,
    output cpu_pkg::byte_t     o_tx_data,
    output logic               o_tx_start,
    output cpu_pkg::du_state_t o_state
);

    // Quiet cycles before a bad load is abandoned
    localparam logic [7:0] FLUSH_QUIET = 8'hFF;
    localparam logic [5:0] REPORT_LAST = 6'(`REPORT_BYTES - 1);

    cpu_pkg::du_state_t state;

    cpu_pkg::im_addr_t load_addr;
    cpu_pkg::im_addr_t load_last;
    logic [5:0]        rep_idx;
    logic [7:0]        flush_cnt;
    logic              core_clear;
    logic              tx_start;
    cpu_pkg::byte_t    tx_data;
    cpu_pkg::byte_t    rep_byte;

    // Current report byte, MSB of each word first
    always_comb begin
        case (rep_idx[1:0])
            2'd0:    rep_byte = i_report_word[31:24];
            2'd1:    rep_byte = i_report_word[23:16];
            2'd2:    rep_byte = i_report_word[15:8];
            default: rep_byte = i_report_word[7:0];
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state      <= cpu_pkg::IDLE;
            load_addr  <= '0;
            load_last  <= '0;
            rep_idx    <= '0;
            flush_cnt  <= '0;
            core_clear <= 1'b0;
            tx_start   <= 1'b0;
        end else begin
            core_clear <= 1'b0;
            tx_start   <= 1'b0;

            case (state)
                cpu_pkg::IDLE: begin
                    rep_idx <= '0;
                    if (i_rx_done) begin
                        case (i_rx_data)
                            `CMD_LOAD: begin
                                state      <= cpu_pkg::LOAD_COUNT;
                                core_clear <= 1'b1;
                            end
                            `CMD_RUN:  state <= cpu_pkg::RUN;
                            `CMD_STEP: state <= cpu_pkg::STEP;
                            default:   state <= cpu_pkg::IDLE;
                        endcase
                    end
                end

                cpu_pkg::LOAD_COUNT: begin
                    if (i_rx_done) begin
                        load_addr <= '0;
                        // Last byte address is 4N-1
                        load_last <= {6'(i_rx_data[5:0] - 6'd1), 2'b11};
                        if (i_rx_data == '0 || i_rx_data > 8'(`CPU_IM_WORDS)) begin
                            flush_cnt <= '0;
                            state     <= cpu_pkg::ERROR_FLUSH;
                        end else begin
                            state <= cpu_pkg::LOAD_BYTES;
                        end
                    end
                end

                cpu_pkg::LOAD_BYTES: begin
                    if (i_rx_done) begin
                        load_addr <= load_addr + 1'b1;
                        if (load_addr == load_last) begin
                            state <= cpu_pkg::IDLE;
                        end
                    end
                end

                cpu_pkg::RUN: begin
                    if (i_hlt) begin
                        state <= cpu_pkg::REPORT_SEND;
                    end
                end

                // Enable is high for this one cycle only
                cpu_pkg::STEP: begin
                    state <= cpu_pkg::REPORT_SEND;
                end

                cpu_pkg::REPORT_SEND: begin
                    tx_start <= 1'b1;
                    tx_data  <= rep_byte;
                    state    <= cpu_pkg::REPORT_WAIT;
                end

                cpu_pkg::REPORT_WAIT: begin
                    if (i_tx_done) begin
                        if (rep_idx == REPORT_LAST) begin
                            rep_idx <= '0;
                            state   <= cpu_pkg::IDLE;
                        end else begin
                            rep_idx <= rep_idx + 1'b1;
                            state   <= cpu_pkg::REPORT_SEND;
                        end
                    end
                end

                // Drop the rest of a bad load until the line goes quiet
                cpu_pkg::ERROR_FLUSH: begin
                    if (i_rx_done) begin
                        flush_cnt <= '0;
                    end else if (flush_cnt == FLUSH_QUIET) begin
                        state <= cpu_pkg::IDLE;
                    end else begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end

                default: state <= cpu_pkg::IDLE;
            endcase
        end
    end

    // Program writes land on the edge ending the rx_done cycle
    assign o_im_write = (state == cpu_pkg::LOAD_BYTES) && i_rx_done;
    assign o_im_addr  = load_addr;
    assign o_im_data  = i_rx_data;

    assign o_cpu_enable = (state == cpu_pkg::RUN) || (state == cpu_pkg::STEP);
    assign o_core_clear = core_clear;
    assign o_report_sel = rep_idx[5:2];

    assign o_tx_start = tx_start;
    assign o_tx_data  = tx_data;
    assign o_state    = state;

endmodule

/* hw/instr_mem.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module instr_mem (
    input  logic                             i_clock,
    input  logic                             i_write,
    input  cpu_pkg::im_addr_t                i_waddr,
    input  cpu_pkg::byte_t                   i_wdata,
    input  logic [$clog2(`CPU_IM_WORDS)-1:0] i_raddr,
    output cpu_pkg::word_t                   o_instr
);

    cpu_pkg::word_t mem [`CPU_IM_WORDS];

    logic [$clog2(`CPU_IM_WORDS)-1:0] wword;
    logic [1:0]                       wlane;

    assign wword = i_waddr[7:2];
    assign wlane = i_waddr[1:0];

    // Byte 0 of a word is its most significant byte
    always_ff @(posedge i_clock) begin
        if (i_write) begin
            case (wlane)
                2'd0:    mem[wword][31:24] <= i_wdata;
                2'd1:    mem[wword][23:16] <= i_wdata;
                2'd2:    mem[wword][15:8]  <= i_wdata;
                default: mem[wword][7:0]   <= i_wdata;
            endcase
        end
    end

    // Fetch is asynchronous
    assign o_instr = mem[i_raddr];

endmodule

/* hw/top_of_tops.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module top_of_tops (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_rx_done,
    input  cpu_pkg::byte_t     i_rx_data,
    input  logic               i_tx_done,
    output logic               o_hlt,
    output cpu_pkg::du_state_t o_state,
    output cpu_pkg::byte_t     o_tx_data,
    output logic               o_tx_start
);

    logic                             im_write;
    cpu_pkg::im_addr_t                im_addr;
    cpu_pkg::byte_t                   im_data;
    cpu_pkg::word_t                   instr;
    logic [$clog2(`CPU_IM_WORDS)-1:0] pc;

    logic                             cpu_enable;
    logic                             core_clear;
    logic [3:0]                       report_sel;
    cpu_pkg::word_t                   report_word;
    logic                             halt;

    debug_unit u_debug_unit (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_rx_done     (i_rx_done),
        .i_rx_data     (i_rx_data),
        .i_tx_done     (i_tx_done),
        .i_hlt         (halt),
        .i_report_word (report_word),
        .o_im_write    (im_write),
        .o_im_addr     (im_addr),
        .o_im_data     (im_data),
        .o_cpu_enable  (cpu_enable),
        .o_core_clear  (core_clear),
        .o_report_sel  (report_sel),
        .o_tx_data     (o_tx_data),
        .o_tx_start    (o_tx_start),
        .o_state       (o_state)
    );

    instr_mem u_instr_mem (
        .i_clock (i_clock),
        .i_write (im_write),
        .i_waddr (im_addr),
        .i_wdata (im_data),
        .i_raddr (pc),
        .o_instr (instr)
    );

    data_path u_data_path (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_enable      (cpu_enable),
        .i_clear       (core_clear),
        .i_instr       (instr),
        .i_report_sel  (report_sel),
        .o_pc          (pc),
        .o_hlt         (halt),
        .o_report_word (report_word)
    );

    assign o_hlt = halt;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_top -f tb.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* tb.f */
+incdir+hw
hw/cpu_pkg.sv
hw/instr_mem.sv
hw/data_path.sv
hw/debug_unit.sv
hw/top_of_tops.sv
tb/clock_gen.sv
tb/cpu_checker.sv
tb/tb_top.sv

/* tb/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic o_clock,
    output logic o_rst
);

    initial begin
        o_clock = 1'b0;
        forever #50 o_clock = ~o_clock;
    end

    // Released on the falling edge after three rising edges
    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clock);
        @(negedge o_clock);
        o_rst = 1'b0;
    end

endmodule

/* tb/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
    input logic               i_clock,
    input logic               i_rst,
    input logic               i_tx_start,
    input logic               i_hlt,
    input logic               i_core_clear,
    input cpu_pkg::du_state_t i_state
);

    // One start strobe per report byte
    tx_start_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
        i_tx_start |=> !i_tx_start)
        else $error("o_tx_start held high for more than one cycle");

    tx_start_not_running: assert property (@(posedge i_clock) disable iff (i_rst)
        !(i_tx_start && i_state == cpu_pkg::RUN))
        else $error("o_tx_start pulsed while the core was running");

    // Only the clear pulse of a load may drop the halt level
    hlt_held: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_hlt && !i_core_clear) |=> i_hlt)
        else $error("o_hlt fell without a program load");

    state_onehot: assert property (@(posedge i_clock) disable iff (i_rst)
        $onehot(i_state))
        else $error("o_state is not one-hot");

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_top;

    localparam int NORMAL_DELAY = 20;
    localparam int SLOW_DELAY   = 60;
    localparam int MAX_REPORTS  = 20;
    localparam int HOST_BYTES   = 4 * (2 + 4 * 13) + 20;
    // Every byte at the slowest tx_done delay plus send and wait cycles
    localparam int TIMEOUT_CYCLES =
        (MAX_REPORTS * `REPORT_BYTES + HOST_BYTES) * (SLOW_DELAY + 3) + 2000;

    logic               clk;
    logic               rst;
    logic               rx_done;
    cpu_pkg::byte_t     rx_data;
    logic               tx_done;
    logic               hlt;
    cpu_pkg::du_state_t state;
    cpu_pkg::byte_t     tx_data;
    logic               tx_start;

    cpu_pkg::word_t prog [`CPU_IM_WORDS];
    int             prog_len;
    cpu_pkg::byte_t rep_q [$];
    cpu_pkg::byte_t report [`REPORT_BYTES];
    int             rep_count;
    int             max_delay;
    int             delay;
    int             checks;
    int             errors;

    clock_gen u_clock_gen (.o_clock(clk), .o_rst(rst));

    top_of_tops UUT (
        .i_clock    (clk),
        .i_rst      (rst),
        .i_rx_done  (rx_done),
        .i_rx_data  (rx_data),
        .i_tx_done  (tx_done),
        .o_hlt      (hlt),
        .o_state    (state),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start)
    );

    bind top_of_tops cpu_checker u_cpu_checker (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_tx_start   (o_tx_start),
        .i_hlt        (o_hlt),
        .i_core_clear (core_clear),
        .i_state      (o_state)
    );

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic send_byte(input cpu_pkg::byte_t b);
        @(negedge clk);
        rx_done = 1'b1;
        rx_data = b;
        @(negedge clk);
        rx_done = 1'b0;
    endtask

    // Body of n random ALU ops, then HALT
    task automatic make_program(input int n);
        logic [3:0]  op;
        logic [15:0] imm;
        int          sel;
        for (int i = 0; i < n; i++) begin
            sel = int'($urandom % 8);
            op  = (sel < 4) ? 4'd1 : 4'(sel - 2);
            imm = 16'($urandom);
            imm[15] = ($urandom % 4) != 0;
            prog[i] = {op, 3'($urandom), 3'($urandom), 3'($urandom), 3'b000, imm};
        end
        prog[n]  = {4'hF, 28'h0};
        prog_len = n + 1;
    endtask

    task automatic load_program();
        send_byte(`CMD_LOAD);
        send_byte(8'(prog_len));
        for (int i = 0; i < prog_len; i++) begin
            send_byte(prog[i][31:24]);
            send_byte(prog[i][23:16]);
            send_byte(prog[i][15:8]);
            send_byte(prog[i][7:0]);
        end
    endtask

    // Complete once all bytes are in and the FSM is back in IDLE
    task automatic get_report();
        while (!(rep_q.size() >= `REPORT_BYTES && state == cpu_pkg::IDLE)) @(negedge clk);
        rep_count = rep_q.size();
        for (int n = 0; n < `REPORT_BYTES; n++) report[n] = rep_q[n];
        rep_q.delete();
    endtask

    // PC and r0..r7 after a number of instructions, or at HALT
    function automatic logic [8:0][31:0] ref_state(input int steps);
        logic [31:0]      r [8];
        logic [31:0]      ins;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      res;
        logic             wr;
        int               pc;
        logic [8:0][31:0] st;
        for (int i = 0; i < 8; i++) r[i] = '0;
        pc = 0;
        for (int n = 0; n < steps; n++) begin
            ins = prog[pc];
            if (ins[31:28] == 4'd15) break;
            a  = r[ins[24:22]];
            b  = r[ins[21:19]];
            wr = 1'b1;
            case (ins[31:28])
                4'd1:    res = a + {{16{ins[15]}}, ins[15:0]};
                4'd2:    res = a + b;
                4'd3:    res = a - b;
                4'd4:    res = a & b;
                4'd5:    res = a | b;
                default: wr = 1'b0;
            endcase
            if (wr && ins[27:25] != 3'd0) r[ins[27:25]] = res;
            pc++;
        end
        st[0] = 32'(pc);
        for (int i = 0; i < 8; i++) st[i + 1] = r[i];
        return st;
    endfunction

    task automatic compare_report(input string name, input logic [8:0][31:0] exp);
        cpu_pkg::word_t act;
        check({name, " byte count"}, `REPORT_BYTES, rep_count);
        for (int w = 0; w < 9; w++) begin
            act = {report[4 * w], report[4 * w + 1], report[4 * w + 2], report[4 * w + 3]};
            check($sformatf("%s word %0d", name, w), exp[w], act);
        end
    endtask

    task automatic run_to_halt(input string name);
        send_byte(`CMD_RUN);
        while (!hlt) @(negedge clk);
        get_report();
        compare_report(name, ref_state(1000));
        check({name, " r0"}, 32'h0, {report[4], report[5], report[6], report[7]});
    endtask

    // UART transmitter model
    always begin
        @(negedge clk);
        if (tx_start) begin
            rep_q.push_back(tx_data);
            delay = 1 + int'($urandom % max_delay);
            repeat (delay - 1) @(negedge clk);
            tx_done = 1'b1;
            @(negedge clk);
            tx_done = 1'b0;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the DUT stopped answering before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rx_done   = 1'b0;
        rx_data   = '0;
        tx_done   = 1'b0;
        max_delay = NORMAL_DELAY;
        checks    = 0;
        errors    = 0;
        rep_count = 0;
        prog_len  = 0;
        void'($urandom(28));
        @(negedge rst);
        @(negedge clk);

        check("reset tx_start", 0, tx_start);
        check("reset hlt", 0, hlt);
        check("reset state", cpu_pkg::IDLE, state);
        send_byte(8'h11);
        repeat (40) @(negedge clk);
        check("stray byte reports", 0, rep_q.size());

        make_program(4 + int'($urandom % 9));
        load_program();
        run_to_halt("run");

        make_program(4 + int'($urandom % 9));
        load_program();
        for (int k = 1; k <= prog_len; k++) begin
            send_byte(`CMD_STEP);
            get_report();
            compare_report($sformatf("step %0d", k), ref_state(k));
        end

        send_byte(`CMD_STEP);
        get_report();
        compare_report("step after halt", ref_state(1000));
        check("step after halt hlt", 1, hlt);

        make_program(4 + int'($urandom % 9));
        load_program();
        check("reload hlt", 0, hlt);
        send_byte(`CMD_STEP);
        get_report();
        compare_report("reload first step", ref_state(1));
        run_to_halt("reload run");

        max_delay = SLOW_DELAY;
        make_program(4 + int'($urandom % 9));
        load_program();
        run_to_halt("slow tx");
        max_delay = NORMAL_DELAY;

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
